// File: project.f
fc_pkg.sv
fc_mac_decode.sv
fc_mac_execute.sv
fc_result.sv
fc_core.sv
fc_core_chk.sv
tb_fc_core.sv

// File: tb_fc_core.sv
/*
  Testbench for the FC core with a neuron table, reference model,
  random input gaps and output stalls, result monitor and watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fc_core;

  localparam int CLK_PERIOD = 8;
  localparam int NUM        = 10;
  localparam int SHIFT      = 6;

  logic             clk = 1'b0;
  logic             rstn;
  logic             s_valid;
  logic             s_ready;
  fc_pkg::beat_t    s_beat;
  logic             m_valid;
  logic             m_ready;
  fc_pkg::result_t  m_result;

  // Neuron table with feature and weight 0 in the top byte
  int          n_tab [NUM];
  logic [63:0] feat_tab [NUM];
  logic [63:0] wgt_tab [NUM];
  int          bias_tab [NUM];
  bit          lend_tab [NUM];

  fc_pkg::result_t exp_q [$];
  int              row_q [$];
  int              seed = 32'hbd98_7023;
  int              total_beats = 0;
  int              errors = 0;
  int              checks = 0;
  bit              random_mode = 1'b0;
  bit              table_done = 1'b0;
  fc_pkg::result_t mon_exp;
  int              mon_row;
  bit              mon_ok;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fc_core #(
    .QUANT_SHIFT (SHIFT)
  ) UUT (
    .clk      (clk),
    .rstn     (rstn),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .s_beat   (s_beat),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_result (m_result)
  );

  task automatic set_row(int r, int n, logic [63:0] f, logic [63:0] w, int b, bit le);
    n_tab[r]    = n;
    feat_tab[r] = f;
    wgt_tab[r]  = w;
    bias_tab[r] = b;
    lend_tab[r] = le;
    total_beats += n;
  endtask

  task automatic build_table();
    // Layer 0 mixes signs and covers saturation, negative, zero and a tie at 127
    set_row(0, 4, {8'd10, -8'sd10, 8'h80, 8'd7, 32'd0},
            {8'd20, -8'sd30, 8'd3, -8'sd9, 32'd0}, 1000, 1'b0);
    set_row(1, 2, {8'h80, 8'h80, 48'd0}, {8'h80, 8'h80, 48'd0}, 0, 1'b0);
    set_row(2, 3, {8'd50, -8'sd60, 8'd70, 40'd0}, {-8'sd90, 8'd40, -8'sd80, 40'd0}, 100, 1'b0);
    set_row(3, 1, {8'd64, 56'd0}, {8'd64, 56'd0}, -4096, 1'b0);
    set_row(4, 8, {8{8'd127}}, {8{8'd1}}, 0, 1'b0);
    set_row(5, 2, {8'h80, 8'h80, 48'd0}, {8'h80, 8'h80, 48'd0}, 0, 1'b1);
    // Layer 1 starts its index and max over, and its max stays below 127
    set_row(6, 2, {-8'sd7, 8'd9, 48'd0}, {-8'sd8, -8'sd9, 48'd0}, 2000, 1'b0);
    set_row(7, 5, {8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 24'd0},
            {-8'sd1, -8'sd2, -8'sd3, -8'sd4, -8'sd5, 24'd0}, -200, 1'b0);
    set_row(8, 1, {8'd127, 56'd0}, {8'h80, 56'd0}, 22000, 1'b0);
    set_row(9, 3, {-8'sd1, -8'sd1, -8'sd1, 40'd0}, {-8'sd1, -8'sd1, -8'sd1, 40'd0}, 7000, 1'b1);
  endtask

  // ReLU of the biased dot product, scaled down and clipped to 127
  function automatic int model_act(int r);
    int total;
    int f;
    int w;
    int q;
    total = bias_tab[r];
    for (int k = 0; k < n_tab[r]; k++) begin
      f = $signed(feat_tab[r][63-8*k -: 8]);
      w = $signed(wgt_tab[r][63-8*k -: 8]);
      total += f * w;
    end
    if (total < 0) return 0;
    q = total / (2 ** SHIFT);
    return (q > 127) ? 127 : q;
  endfunction

  task automatic load_expected();
    fc_pkg::result_t e;
    int idx;
    int max_v;
    int max_i;
    int a;
    idx = 0;
    max_v = 0;
    max_i = 0;
    for (int r = 0; r < NUM; r++) begin
      a = model_act(r);
      if (a >= max_v) begin
        max_v = a;
        max_i = idx;
      end
      e.act       = 8'(a);
      e.idx       = 4'(idx);
      e.layer_end = lend_tab[r];
      e.max_idx   = 4'(max_i);
      exp_q.push_back(e);
      row_q.push_back(r);
      idx = lend_tab[r] ? 0 : idx + 1;
      if (lend_tab[r]) begin
        max_v = 0;
        max_i = 0;
      end
    end
  endtask

  // Called at a falling edge and returns at the falling edge after the last transfer
  task automatic drive_row(int r);
    for (int k = 0; k < n_tab[r]; k++) begin
      while (random_mode && (($random(seed) & 3) == 0)) begin
        s_valid = 1'b0;
        @(negedge clk);
      end
      s_valid          = 1'b1;
      s_beat.feat      = feat_tab[r][63-8*k -: 8];
      s_beat.weight    = wgt_tab[r][63-8*k -: 8];
      // Bias rides only on the last beat of a neuron
      s_beat.bias      = (k == n_tab[r] - 1) ? 16'(bias_tab[r]) : 16'(0);
      s_beat.first     = (k == 0);
      s_beat.last      = (k == n_tab[r] - 1);
      s_beat.layer_end = lend_tab[r];
      @(posedge clk);
      while (!s_ready) @(posedge clk);
      @(negedge clk);
    end
  endtask

  always @(negedge clk) begin
    if (random_mode) m_ready = (($random(seed) & 3) != 0);
    else m_ready = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rstn && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        $display("output word arrived with no neuron pending");
        errors++;
      end else begin
        mon_exp = exp_q.pop_front();
        mon_row = row_q.pop_front();
        mon_ok  = 1'b1;
        if (m_result.act !== mon_exp.act) begin
          $display("mismatch act: expected %h, got %h", mon_exp.act, m_result.act);
          mon_ok = 1'b0;
        end
        if (m_result.idx !== mon_exp.idx) begin
          $display("mismatch idx: expected %h, got %h", mon_exp.idx, m_result.idx);
          mon_ok = 1'b0;
        end
        if (m_result.layer_end !== mon_exp.layer_end) begin
          $display("mismatch layer_end: expected %h, got %h",
                   mon_exp.layer_end, m_result.layer_end);
          mon_ok = 1'b0;
        end
        if (mon_exp.layer_end && (m_result.max_idx !== mon_exp.max_idx)) begin
          $display("mismatch max_idx: expected %h, got %h", mon_exp.max_idx, m_result.max_idx);
          mon_ok = 1'b0;
        end
        checks++;
        if (!mon_ok) errors++;
        $display("neuron %0d: act %h idx %0d %s", mon_row, m_result.act, m_result.idx,
                 mon_ok ? "ok" : "FAILED");
      end
    end
  end

  // Watchdog allows 40 cycles per beat over both passes
  initial begin
    wait (table_done);
    #(2 * total_beats * 40 * CLK_PERIOD);
    $display("timeout: %0d expected outputs never arrived", exp_q.size());
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rstn    = 1'b0;
    s_valid = 1'b0;
    s_beat  = '0;
    m_ready = 1'b1;
    build_table();
    table_done = 1'b1;
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    // Pass 0 runs at full rate and pass 1 with gaps and stalls
    for (int pass = 0; pass < 2; pass++) begin
      random_mode = (pass == 1);
      load_expected();
      for (int r = 0; r < NUM; r++) drive_row(r);
      s_valid = 1'b0;
      while (exp_q.size() != 0) @(negedge clk);
    end
    random_mode = 1'b0;
    repeat (10) @(negedge clk);
    errors += UUT.u_chk.fail_cnt;
    $display("%0d neurons checked, %0d errors, %0d assertion failures",
             checks, errors, UUT.u_chk.fail_cnt);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fc_core_chk.sv
/*
  Bound assertions for the FC core output handshake,
  the ready rule and the state right after reset
*/
`timescale 1ns/1ps
`default_nettype none

module fc_core_chk (
  input  logic             clk,
  input  logic             rstn,
  input  logic             s_ready,
  input  logic             m_valid,
  input  logic             m_ready,
  input  fc_pkg::result_t  m_result
);

  int fail_cnt = 0;

  // A stalled output word keeps its valid and its data
  assert property (@(posedge clk) disable iff (!rstn)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_result)))
  else begin
    $error("output word changed while stalled");
    fail_cnt++;
  end

  assert property (@(posedge clk) !rstn |=> !m_valid)
  else begin
    $error("m_valid high in the cycle after reset");
    fail_cnt++;
  end

  // Input side opens whenever the output register is free
  assert property (@(posedge clk) disable iff (!rstn) s_ready == (!m_valid || m_ready))
  else begin
    $error("s_ready does not follow the output register state");
    fail_cnt++;
  end

endmodule

bind fc_core fc_core_chk u_chk (
  .clk      (clk),
  .rstn     (rstn),
  .s_ready  (s_ready),
  .m_valid  (m_valid),
  .m_ready  (m_ready),
  .m_result (m_result)
);

`default_nettype wire

// File: fc_core.sv
/*
  Top level of the FC layer core: decode, execute and result
  stages behind a valid/ready stream on each side
*/
`timescale 1ns/1ps
`default_nettype none

module fc_core #(
  parameter int QUANT_SHIFT = 6
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             s_valid,
  output logic             s_ready,
  input  fc_pkg::beat_t    s_beat,
  output logic             m_valid,
  input  logic             m_ready,
  output fc_pkg::result_t  m_result
);

  logic          advance;
  logic          dec_valid;
  fc_pkg::pp_t   dec_pp;
  logic          acc_valid;
  fc_pkg::acc_t  acc;

  assign s_ready = advance;

  fc_mac_decode u_decode (
    .clk       (clk),
    .rstn      (rstn),
    .advance   (advance),
    .in_valid  (s_valid & advance),
    .in_beat   (s_beat),
    .dec_valid (dec_valid),
    .dec_pp    (dec_pp)
  );

  fc_mac_execute u_execute (
    .clk       (clk),
    .rstn      (rstn),
    .advance   (advance),
    .dec_valid (dec_valid),
    .dec_pp    (dec_pp),
    .acc_valid (acc_valid),
    .acc       (acc)
  );

  fc_result #(
    .QUANT_SHIFT (QUANT_SHIFT)
  ) u_result (
    .clk       (clk),
    .rstn      (rstn),
    .acc_valid (acc_valid),
    .acc       (acc),
    .m_ready   (m_ready),
    .advance   (advance),
    .m_valid   (m_valid),
    .m_result  (m_result)
  );

endmodule

`default_nettype wire

// File: fc_result.sv
/*
  Result stage: bias add, ReLU with saturating quantization,
  neuron index, running argmax and the output register
*/
`timescale 1ns/1ps
`default_nettype none

module fc_result #(
  parameter int QUANT_SHIFT = 6
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             acc_valid,
  input  fc_pkg::acc_t     acc,
  input  logic             m_ready,
  output logic             advance,
  output logic             m_valid,
  output fc_pkg::result_t  m_result
);

  logic signed [fc_pkg::ACC_W-1:0] bias_ext;
  logic signed [fc_pkg::ACC_W-1:0] sum_r;
  logic                            sum_v;
  logic                            sum_le;

  logic [fc_pkg::ACC_W-1:0]  shifted;
  logic [fc_pkg::DATA_W-1:0] act;
  logic [fc_pkg::IDX_W-1:0]  cnt;
  logic [fc_pkg::DATA_W-1:0] max_val;
  logic [fc_pkg::IDX_W-1:0]  max_idx_r;
  logic                      take_max;

  // Whole pipeline moves when the output word is free
  assign advance = ~m_valid | m_ready;

  ////////////////////////////////////////////////////////////
  // Bias add
  ////////////////////////////////////////////////////////////
  assign bias_ext = {{(fc_pkg::ACC_W-fc_pkg::BIAS_W){acc.bias[fc_pkg::BIAS_W-1]}}, acc.bias};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sum_v <= 1'b0;
    end else if (advance) begin
      sum_v <= acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      sum_r  <= acc.sum + bias_ext;
      sum_le <= acc.layer_end;
    end
  end

  ////////////////////////////////////////////////////////////
  // ReLU, quantize, argmax
  ////////////////////////////////////////////////////////////
  assign shifted = sum_r >> QUANT_SHIFT;

  always_comb begin
    if (sum_r[fc_pkg::ACC_W-1]) begin
      act = '0;
    end else if (shifted > fc_pkg::ACT_MAX) begin
      act = fc_pkg::ACT_MAX;
    end else begin
      act = shifted[fc_pkg::DATA_W-1:0];
    end
  end

  // Ties move the max forward, so the last equal value wins
  assign take_max = (act >= max_val);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_valid   <= 1'b0;
      cnt       <= '0;
      max_val   <= '0;
      max_idx_r <= '0;
    end else if (advance) begin
      m_valid <= sum_v;
      if (sum_v && sum_le) begin
        cnt       <= '0;
        max_val   <= '0;
        max_idx_r <= '0;
      end else if (sum_v) begin
        cnt <= cnt + 1'b1;
        if (take_max) begin
          max_val   <= act;
          max_idx_r <= cnt;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance && sum_v) begin
      m_result.act       <= act;
      m_result.idx       <= cnt;
      m_result.layer_end <= sum_le;
      m_result.max_idx   <= take_max ? cnt : max_idx_r;
    end
  end

endmodule

`default_nettype wire

// File: fc_mac_execute.sv
/*
  Execute stage: two-step partial product reduction, sign
  restore and the dot product accumulator
*/
`timescale 1ns/1ps
`default_nettype none

module fc_mac_execute (
  input  logic          clk,
  input  logic          rstn,
  input  logic          advance,
  input  logic          dec_valid,
  input  fc_pkg::pp_t   dec_pp,
  output logic          acc_valid,
  output fc_pkg::acc_t  acc
);

  logic [3:0][fc_pkg::PROD_W-1:0] pair;
  logic [3:0][fc_pkg::PROD_W-1:0] pair_r;
  logic                           v1;
  logic                           neg1;
  logic                           first1;
  logic                           last1;
  logic                           le1;
  logic signed [fc_pkg::BIAS_W-1:0] bias1;

  logic [fc_pkg::PROD_W-1:0]        mag;
  logic [fc_pkg::ACC_W-1:0]         mag_ext;
  logic signed [fc_pkg::ACC_W-1:0]  prod_r;
  logic                             v2;
  logic                             first2;
  logic                             last2;
  logic                             le2;
  logic signed [fc_pkg::BIAS_W-1:0] bias2;

  logic signed [fc_pkg::ACC_W-1:0]  acc_sum;

  ////////////////////////////////////////////////////////////
  // Stage 1, partial products added in pairs
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int j = 0; j < 4; j++) begin
      pair[j] = dec_pp.pp[2*j] + dec_pp.pp[2*j+1];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      pair_r <= pair;
      neg1   <= dec_pp.neg;
      first1 <= dec_pp.first;
      last1  <= dec_pp.last;
      le1    <= dec_pp.layer_end;
      bias1  <= dec_pp.bias;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2, final magnitude and sign
  ////////////////////////////////////////////////////////////
  // Magnitude never exceeds 128*128, so 16 bits hold it
  assign mag     = pair_r[0] + pair_r[1] + pair_r[2] + pair_r[3];
  assign mag_ext = {{(fc_pkg::ACC_W-fc_pkg::PROD_W){1'b0}}, mag};

  always_ff @(posedge clk) begin
    if (advance) begin
      prod_r <= neg1 ? (~mag_ext + 1'b1) : mag_ext;
      first2 <= first1;
      last2  <= last1;
      le2    <= le1;
      bias2  <= bias1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 3, accumulator
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      v1        <= 1'b0;
      v2        <= 1'b0;
      acc_valid <= 1'b0;
      acc_sum   <= '0;
    end else if (advance) begin
      v1        <= dec_valid;
      v2        <= v1;
      // Only a finished neuron goes on to the result stage
      acc_valid <= v2 & last2;
      if (v2) begin
        acc_sum <= first2 ? prod_r : acc_sum + prod_r;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance && v2) begin
      acc.bias      <= bias2;
      acc.layer_end <= le2;
    end
  end

  assign acc.sum = acc_sum;

endmodule

`default_nettype wire

// File: fc_mac_decode.sv
/*
  Operand decode stage: magnitudes, product sign and the
  shifted partial products, registered with the beat flags
*/
`timescale 1ns/1ps
`default_nettype none

module fc_mac_decode (
  input  logic            clk,
  input  logic            rstn,
  input  logic            advance,
  input  logic            in_valid,
  input  fc_pkg::beat_t   in_beat,
  output logic            dec_valid,
  output fc_pkg::pp_t     dec_pp
);

  logic [fc_pkg::DATA_W-1:0]                     f_mag;
  logic [fc_pkg::DATA_W-1:0]                     w_mag;
  logic [fc_pkg::PROD_W-1:0]                     f_wide;
  logic [fc_pkg::DATA_W-1:0][fc_pkg::PROD_W-1:0] pp;

  // Two's complement magnitude, -128 maps to 8'h80
  assign f_mag = in_beat.feat[fc_pkg::DATA_W-1] ? (~in_beat.feat + 1'b1) : in_beat.feat;
  assign w_mag = in_beat.weight[fc_pkg::DATA_W-1] ? (~in_beat.weight + 1'b1) : in_beat.weight;

  assign f_wide = {{(fc_pkg::PROD_W-fc_pkg::DATA_W){1'b0}}, f_mag};

  // One row per weight bit, already aligned to its bit position
  always_comb begin
    for (int i = 0; i < fc_pkg::DATA_W; i++) begin
      pp[i] = w_mag[i] ? (f_wide << i) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dec_valid <= 1'b0;
    end else if (advance) begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      dec_pp.pp        <= pp;
      dec_pp.neg       <= in_beat.feat[fc_pkg::DATA_W-1] ^ in_beat.weight[fc_pkg::DATA_W-1];
      dec_pp.first     <= in_beat.first;
      dec_pp.last      <= in_beat.last;
      dec_pp.layer_end <= in_beat.layer_end;
      dec_pp.bias      <= in_beat.bias;
    end
  end

endmodule

`default_nettype wire

// File: fc_pkg.sv
/*
  Shared widths, activation limit and the packed payload types
  passed between the decode, execute and result stages
*/
`default_nettype none

package fc_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int DATA_W = 8;
  localparam int PROD_W = 16;
  localparam int ACC_W  = 28;
  localparam int BIAS_W = 16;
  localparam int IDX_W  = 4;

  // Largest activation after quantization
  localparam logic [DATA_W-1:0] ACT_MAX = DATA_W'(127);

  ////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic signed [DATA_W-1:0] feat;
    logic signed [DATA_W-1:0] weight;
    logic signed [BIAS_W-1:0] bias;   // only meaningful with last
    logic                     first;
    logic                     last;
    logic                     layer_end;
  } beat_t;

  typedef struct packed {
    logic [DATA_W-1:0][PROD_W-1:0] pp;
    logic                          neg;
    logic                          first;
    logic                          last;
    logic                          layer_end;
    logic signed [BIAS_W-1:0]      bias;
  } pp_t;

  typedef struct packed {
    logic signed [ACC_W-1:0]  sum;
    logic signed [BIAS_W-1:0] bias;
    logic                     layer_end;
  } acc_t;

  // max_idx is valid on the layer_end word
  typedef struct packed {
    logic [DATA_W-1:0] act;
    logic [IDX_W-1:0]  idx;
    logic              layer_end;
    logic [IDX_W-1:0]  max_idx;
  } result_t;

endpackage

`default_nettype wire
